/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_daq_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
FILELIST  ?= list.f
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/daq_checker.sv */
`timescale 1ns/1ps

module daq_checker import daq_pkg::*; (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  int                           i_test_id,
    input  wb_req_t                      i_wb,
    input  logic [DAT_W-1:0]             i_wb_dat,
    input  logic                         i_wb_ack,
    input  logic [SENSE_W-1:0]           i_sense,
    input  board_ctrl_t                  i_board,
    input  logic [N_SRC-1:0]             i_src_req,
    input  logic [N_SRC-1:0]             i_src_hold,
    input  logic [N_SRC-1:0]             i_src_read,
    input  logic                         i_arb_ready,
    input  logic                         i_arb_write,
    input  logic [WORD_W-1:0]            i_arb_data,
    input  logic [N_SRC-1:0]             i_push,
    input  logic [N_SRC-1:0][WORD_W-1:0] i_push_data,
    output int                           o_bus_errs,
    output int                           o_arb_errs
);

    logic              ack_m;
    logic              rd_pend;
    logic [DAT_W-1:0]  exp_dat;
    logic              cfg_m;
    logic [CTRL_W-1:0] ctrl_m;
    int                last_m;
    logic              wr_pend;
    logic [WORD_W-1:0] exp_word;
    logic [WORD_W-1:0] model_q [N_SRC][$];

    function automatic string test_label(input int id);
        case (id)
            1: return "sys_const";
            2: return "cfg_flag";
            3: return "board_ctrl";
            4: return "unmapped";
            5: return "arb_random";
            6: return "arb_hold";
            default: return "idle";
        endcase
    endfunction

    task automatic value_error(input logic is_bus, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        $display("error %s %s: expected 0x%0h, actual 0x%0h",
                 test_label(i_test_id), what, exp, act);
        if (is_bus) begin
            o_bus_errs++;
        end else begin
            o_arb_errs++;
        end
    endtask

    function automatic logic [DAT_W-1:0] expect_read(input logic [ADR_W-1:0] a);
        if (a >= SYS_BASE && a <= SYS_HIGH) begin
            case (a[7:0])
                8'd0: return FW_VERSION;
                8'd1: return FW_MINOR;
                8'd2: return FW_MAJOR;
                8'd3: return BOARD_ID;
                8'd4: return {7'b0, cfg_m};
                default: return '0;
            endcase
        end
        if (a >= CTRL_BASE && a <= CTRL_HIGH) begin
            case (a[7:0])
                8'd0: return {ctrl_m[7:4], i_sense};
                8'd1: return ctrl_m[15:8];
                default: return '0;
            endcase
        end
        return '0;
    endfunction

    function automatic void apply_write(input logic [ADR_W-1:0] a, input logic [DAT_W-1:0] d);
        logic [CTRL_W-1:0] wanted;
        wanted = ctrl_m;
        if (a >= SYS_BASE && a <= SYS_HIGH && a[7:0] == 8'd5) begin
            cfg_m = d[0];
        end
        if (a >= CTRL_BASE && a <= CTRL_HIGH && a[7:0] == 8'd0) begin
            wanted[7:0] = d;
        end
        if (a >= CTRL_BASE && a <= CTRL_HIGH && a[7:0] == 8'd1) begin
            wanted[15:8] = d;
        end
        // Input bits keep their value
        ctrl_m = (wanted & CTRL_DIR_MASK) | (ctrl_m & ~CTRL_DIR_MASK);
    endfunction

    always @(posedge i_clk) begin : check_cycle
        logic [N_SRC-1:0] exp_read;
        board_ctrl_t      exp_board;
        int               g;
        int               idx;
        if (i_rst) begin
            ack_m   = 1'b0;
            rd_pend = 1'b0;
            cfg_m   = 1'b0;
            ctrl_m  = '0;
            last_m  = N_SRC - 1;
            wr_pend = 1'b0;
            for (int i = 0; i < N_SRC; i++) begin
                model_q[i].delete();
            end
        end else begin
            if (i_wb_ack !== ack_m) begin
                value_error(1'b1, "ack", 32'(ack_m), 32'(i_wb_ack));
            end else if (ack_m && rd_pend && i_wb_dat !== exp_dat) begin
                value_error(1'b1, "read data", 32'(exp_dat), 32'(i_wb_dat));
            end
            exp_board = '{mgt_ref_sel: ~ctrl_m[15], lemo_mux: ctrl_m[14:7],
                          ntc_mux: ctrl_m[6:4]};
            if (i_board !== exp_board) begin
                value_error(1'b1, "board outputs", 32'(exp_board), 32'(i_board));
            end
            if (i_wb.cyc && i_wb.stb && !ack_m) begin
                rd_pend = !i_wb.we;
                exp_dat = expect_read(i_wb.adr);
                if (i_wb.we) begin
                    apply_write(i_wb.adr, i_wb.dat);
                end
            end
            ack_m = i_wb.cyc && i_wb.stb && !ack_m;

            if (i_arb_write !== wr_pend) begin
                value_error(1'b0, "write strobe", 32'(wr_pend), 32'(i_arb_write));
            end else if (wr_pend && i_arb_data !== exp_word) begin
                value_error(1'b0, "output word", exp_word, i_arb_data);
            end
            for (int i = 0; i < N_SRC; i++) begin
                if (i_push[i]) begin
                    model_q[i].push_back(i_push_data[i]);
                end
            end
            // Holder first, then first requester above the last read source
            exp_read = '0;
            g = -1;
            if (i_arb_ready && |i_src_req) begin
                if (i_src_req[last_m] && i_src_hold[last_m]) begin
                    g = last_m;
                end
                for (int k = 1; k <= N_SRC; k++) begin
                    idx = (last_m + k) % N_SRC;
                    if (g < 0 && i_src_req[idx]) begin
                        g = idx;
                    end
                end
            end
            if (g >= 0) begin
                exp_read[g] = 1'b1;
            end
            if (i_src_read !== exp_read) begin
                value_error(1'b0, "read select", 32'(exp_read), 32'(i_src_read));
            end
            wr_pend = 1'b0;
            for (int i = 0; i < N_SRC; i++) begin
                if (i_src_read[i]) begin
                    last_m  = i;
                    wr_pend = 1'b1;
                    if (model_q[i].size() == 0) begin
                        $display("%s: source %0d was read while its queue was empty",
                                 test_label(i_test_id), i);
                        o_arb_errs++;
                    end else begin
                        exp_word = model_q[i].pop_front();
                    end
                end
            end
        end
    end

endmodule

/* bench/tb_daq_core.sv */
`timescale 1ns/1ps

module tb_daq_core import daq_pkg::*; ();

    localparam int RST_CYCLES     = 5;
    localparam int N_CFG_OPS      = 40;
    localparam int N_GPIO_OPS     = 60;
    localparam int N_UNMAPPED     = 40;
    localparam int N_BUS_OPS      = 4 + 1 + N_CFG_OPS + N_GPIO_OPS + N_UNMAPPED + 3;
    localparam int CYC_PER_ACCESS = 3;
    localparam int ARB_CYCLES     = 1500;
    localparam int HOLD_CYCLES    = 1500;
    localparam int TOTAL_CYCLES   = RST_CYCLES + N_BUS_OPS * CYC_PER_ACCESS
                                  + ARB_CYCLES + HOLD_CYCLES + 4;
    localparam int TIMEOUT_NS     = TOTAL_CYCLES * 8 + 1000;

    logic                         bus_clk;
    logic                         bus_rst;
    wb_req_t                      wb;
    logic [DAT_W-1:0]             wb_dat;
    logic                         wb_ack;
    logic [SENSE_W-1:0]           sense;
    board_ctrl_t                  board;
    logic [N_SRC-1:0]             src_req;
    logic [N_SRC-1:0]             src_hold;
    logic [N_SRC-1:0]             src_read;
    logic [N_SRC-1:0][WORD_W-1:0] src_data;
    logic                         arb_ready;
    logic                         arb_write;
    logic [WORD_W-1:0]            arb_data;
    logic [N_SRC-1:0]             push;
    logic [N_SRC-1:0][WORD_W-1:0] push_data;
    int                           test_id;
    int                           bus_errs;
    int                           arb_errs;
    logic [15:0]                  lfsr;
    logic                         hold_heavy;
    logic [ADR_W-1:0]             adr;
    logic [ADR_W-1:0]             ofs;
    // Source FIFOs as the readout channels would present them
    logic [WORD_W-1:0]            srcq [N_SRC][$];

    always #4 bus_clk = ~bus_clk;

    daq_core u_daq_core (
        .i_bus_clk   (bus_clk),
        .i_bus_rst   (bus_rst),
        .i_wb        (wb),
        .o_wb_dat    (wb_dat),
        .o_wb_ack    (wb_ack),
        .i_sense     (sense),
        .o_board     (board),
        .i_src_req   (src_req),
        .i_src_hold  (src_hold),
        .i_src_data  (src_data),
        .o_src_read  (src_read),
        .i_arb_ready (arb_ready),
        .o_arb_write (arb_write),
        .o_arb_data  (arb_data)
    );

    daq_checker u_daq_checker (
        .i_clk       (bus_clk),
        .i_rst       (bus_rst),
        .i_test_id   (test_id),
        .i_wb        (wb),
        .i_wb_dat    (wb_dat),
        .i_wb_ack    (wb_ack),
        .i_sense     (sense),
        .i_board     (board),
        .i_src_req   (src_req),
        .i_src_hold  (src_hold),
        .i_src_read  (src_read),
        .i_arb_ready (arb_ready),
        .i_arb_write (arb_write),
        .i_arb_data  (arb_data),
        .i_push      (push),
        .i_push_data (push_data),
        .o_bus_errs  (bus_errs),
        .o_arb_errs  (arb_errs)
    );

    // Galois LFSR over x^16+x^14+x^13+x^11+1 stepped once per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    // One clock of source traffic, ready and sense
    task automatic tick();
        logic [WORD_W-1:0] w;
        @(posedge bus_clk);
        for (int i = 0; i < N_SRC; i++) begin
            if (src_read[i] && srcq[i].size() > 0) begin
                void'(srcq[i].pop_front());
            end
            push[i] <= 1'b0;
            if (srcq[i].size() < 6 && lfsr_bits(3) == 0) begin
                w = {4'(i), 28'(lfsr_bits(28))};
                srcq[i].push_back(w);
                push[i]      <= 1'b1;
                push_data[i] <= w;
            end
            src_req[i] <= (srcq[i].size() != 0);
            if (srcq[i].size() != 0) begin
                src_data[i] <= srcq[i][0];
            end else begin
                src_data[i] <= '0;
            end
            src_hold[i] <= hold_heavy ? (lfsr_bits(2) != 0) : 1'(lfsr_bits(1));
        end
        arb_ready <= (lfsr_bits(2) != 0);
        sense     <= SENSE_W'(lfsr_bits(SENSE_W));
    endtask

    task automatic wb_access(input logic we, input logic [ADR_W-1:0] a,
                             input logic [DAT_W-1:0] d);
        tick();
        wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: a, dat: d};
        do begin
            tick();
        end while (!wb_ack);
        wb <= '0;
    endtask

    initial begin
        bus_clk    = 1'b0;
        bus_rst    = 1'b1;
        wb         = '0;
        sense      = '0;
        src_req    = '0;
        src_hold   = '0;
        src_data   = '0;
        arb_ready  = 1'b0;
        push       = '0;
        push_data  = '0;
        test_id    = 0;
        hold_heavy = 1'b0;
        lfsr       = 16'd92;
        repeat (RST_CYCLES) @(posedge bus_clk);
        bus_rst <= 1'b0;

        test_id <= 1;
        for (int k = 0; k < 4; k++) begin
            wb_access(1'b0, SYS_BASE + ADR_W'(k), '0);
        end

        test_id <= 2;
        wb_access(1'b0, SYS_BASE + 16'd4, '0);
        repeat (N_CFG_OPS) begin
            ofs = ADR_W'(lfsr_bits(3) % 6);
            if (lfsr_bits(1) != 0) begin
                wb_access(1'b1, SYS_BASE + ofs, DAT_W'(lfsr_bits(8)));
            end else begin
                wb_access(1'b0, SYS_BASE + 16'd4, '0);
            end
        end

        test_id <= 3;
        repeat (N_GPIO_OPS) begin
            adr = CTRL_BASE + ADR_W'(lfsr_bits(1));
            wb_access(1'(lfsr_bits(1)), adr, DAT_W'(lfsr_bits(8)));
        end

        test_id <= 4;
        repeat (N_UNMAPPED) begin
            adr = ADR_W'(lfsr_bits(16));
            // Pages 0x03 and 0x05 move to 0x0B and 0x0D
            if (adr[15:8] == 8'h03 || adr[15:8] == 8'h05) begin
                adr[11] = ~adr[11];
            end
            wb_access(1'(lfsr_bits(1)), adr, DAT_W'(lfsr_bits(8)));
        end
        wb_access(1'b0, CTRL_BASE, '0);
        wb_access(1'b0, CTRL_BASE + 16'd1, '0);
        wb_access(1'b0, SYS_BASE + 16'd4, '0);

        test_id <= 5;
        repeat (ARB_CYCLES) tick();
        test_id <= 6;
        hold_heavy = 1'b1;
        repeat (HOLD_CYCLES) tick();
        repeat (4) tick();
        // Checker has finished the last edge by now
        @(negedge bus_clk);

        $display("Closing: bus errors %0d, arbiter errors %0d", bus_errs, arb_errs);
        if (bus_errs + arb_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

/* list.f */
rtl/daq_pkg.sv
rtl/wb_addr_decode.sv
rtl/daq_system_regs.sv
rtl/gpio_control.sv
rtl/rrp_arbiter.sv
rtl/daq_core.sv
bench/daq_checker.sv
bench/tb_daq_core.sv

/* rtl/daq_core.sv */
`timescale 1ns/1ps

module daq_core import daq_pkg::*; (
    input  logic                          i_bus_clk,
    input  logic                          i_bus_rst,
    input  wb_req_t                       i_wb,
    output logic [DAT_W-1:0]              o_wb_dat,
    output logic                          o_wb_ack,
    input  logic [SENSE_W-1:0]            i_sense,
    output board_ctrl_t                   o_board,
    input  logic [N_SRC-1:0]              i_src_req,
    input  logic [N_SRC-1:0]              i_src_hold,
    input  logic [N_SRC-1:0][WORD_W-1:0]  i_src_data,
    output logic [N_SRC-1:0]              o_src_read,
    input  logic                          i_arb_ready,
    output logic                          o_arb_write,
    output logic [WORD_W-1:0]             o_arb_data
);

    reg_req_t         sys_req;
    reg_req_t         ctrl_req;
    logic [DAT_W-1:0] sys_rdata;
    logic [DAT_W-1:0] ctrl_rdata;

    wb_addr_decode u_wb_addr_decode (
        .i_bus_clk    (i_bus_clk),
        .i_bus_rst    (i_bus_rst),
        .i_wb         (i_wb),
        .o_wb_dat     (o_wb_dat),
        .o_wb_ack     (o_wb_ack),
        .o_sys_req    (sys_req),
        .i_sys_rdata  (sys_rdata),
        .o_ctrl_req   (ctrl_req),
        .i_ctrl_rdata (ctrl_rdata)
    );

    daq_system_regs u_daq_system_regs (
        .i_bus_clk (i_bus_clk),
        .i_bus_rst (i_bus_rst),
        .i_req     (sys_req),
        .o_rdata   (sys_rdata)
    );

    gpio_control u_gpio_control (
        .i_bus_clk (i_bus_clk),
        .i_bus_rst (i_bus_rst),
        .i_req     (ctrl_req),
        .o_rdata   (ctrl_rdata),
        .i_sense   (i_sense),
        .o_board   (o_board)
    );

    // Merges the readout sources toward the host FIFO
    rrp_arbiter #(
        .N (N_SRC)
    ) u_rrp_arbiter (
        .i_bus_clk (i_bus_clk),
        .i_bus_rst (i_bus_rst),
        .i_req     (i_src_req),
        .i_hold    (i_src_hold),
        .i_data    (i_src_data),
        .o_read    (o_src_read),
        .i_ready   (i_arb_ready),
        .o_write   (o_arb_write),
        .o_data    (o_arb_data)
    );

endmodule

/* rtl/daq_pkg.sv */
package daq_pkg;

    // Bus geometry
    localparam int ADR_W = 16;
    localparam int DAT_W = 8;
    localparam int OFS_W = 8;

    // Address windows of one 256-byte page each
    localparam logic [ADR_W-1:0] SYS_BASE  = 16'h0300;
    localparam logic [ADR_W-1:0] SYS_HIGH  = 16'h03FF;
    localparam logic [ADR_W-1:0] CTRL_BASE = 16'h0500;
    localparam logic [ADR_W-1:0] CTRL_HIGH = 16'h05FF;

    // Firmware readback for the simulation board (board 0)
    localparam logic [DAT_W-1:0] FW_VERSION = 8'd1;
    localparam logic [DAT_W-1:0] FW_MINOR   = 8'd0;
    localparam logic [DAT_W-1:0] FW_MAJOR   = 8'd0;
    localparam logic [DAT_W-1:0] BOARD_ID   = 8'd0;

    // System window offsets
    localparam logic [OFS_W-1:0] SYS_OFS_VERSION       = 8'd0;
    localparam logic [OFS_W-1:0] SYS_OFS_MINOR         = 8'd1;
    localparam logic [OFS_W-1:0] SYS_OFS_MAJOR         = 8'd2;
    localparam logic [OFS_W-1:0] SYS_OFS_BOARD         = 8'd3;
    localparam logic [OFS_W-1:0] SYS_OFS_CONFIGURED    = 8'd4;
    localparam logic [OFS_W-1:0] SYS_OFS_CONFIGURED_WR = 8'd5;

    // Board control
    localparam int CTRL_W = 16;
    localparam logic [CTRL_W-1:0] CTRL_DIR_MASK = 16'hFFF0;
    localparam int SENSE_W = 4;

    // Readout sources
    localparam int N_SRC  = 6;
    localparam int WORD_W = 32;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             rd;
        logic             wr;
        logic [OFS_W-1:0] offset;
        logic [DAT_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic       mgt_ref_sel;
        logic [7:0] lemo_mux;
        logic [2:0] ntc_mux;
    } board_ctrl_t;

endpackage

/* rtl/daq_system_regs.sv */
`timescale 1ns/1ps

module daq_system_regs import daq_pkg::*; (
    input  logic             i_bus_clk,
    input  logic             i_bus_rst,
    input  reg_req_t         i_req,
    output logic [DAT_W-1:0] o_rdata
);

    // Set by software once the reference oscillator is programmed
    logic osc_configured_q;

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            osc_configured_q <= 1'b0;
        end else if (i_req.wr && (i_req.offset == SYS_OFS_CONFIGURED_WR)) begin
            osc_configured_q <= i_req.wdata[0];
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_req.rd) begin
            case (i_req.offset)
                SYS_OFS_VERSION: begin
                    o_rdata = FW_VERSION;
                end
                SYS_OFS_MINOR: begin
                    o_rdata = FW_MINOR;
                end
                SYS_OFS_MAJOR: begin
                    o_rdata = FW_MAJOR;
                end
                SYS_OFS_BOARD: begin
                    o_rdata = BOARD_ID;
                end
                SYS_OFS_CONFIGURED: begin
                    o_rdata = {{(DAT_W-1){1'b0}}, osc_configured_q};
                end
                default: begin
                    o_rdata = '0;
                end
            endcase
        end
    end

endmodule

/* rtl/gpio_control.sv */
`timescale 1ns/1ps

module gpio_control import daq_pkg::*; (
    input  logic               i_bus_clk,
    input  logic               i_bus_rst,
    input  reg_req_t           i_req,
    output logic [DAT_W-1:0]   o_rdata,
    input  logic [SENSE_W-1:0] i_sense,
    output board_ctrl_t        o_board
);

    logic [CTRL_W-1:0] ctrl_q;
    logic [CTRL_W-1:0] ctrl_rd;

    // Only direction-mask bits take write data
    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            ctrl_q <= '0;
        end else if (i_req.wr) begin
            if (i_req.offset == 8'd0) begin
                ctrl_q[7:0] <= (ctrl_q[7:0] & ~CTRL_DIR_MASK[7:0])
                             | (i_req.wdata & CTRL_DIR_MASK[7:0]);
            end
            if (i_req.offset == 8'd1) begin
                ctrl_q[15:8] <= (ctrl_q[15:8] & ~CTRL_DIR_MASK[15:8])
                              | (i_req.wdata & CTRL_DIR_MASK[15:8]);
            end
        end
    end

    // Input bits read back the display-port sense lines
    assign ctrl_rd = {ctrl_q[CTRL_W-1:SENSE_W], i_sense};

    always_comb begin
        o_rdata = '0;
        if (i_req.rd) begin
            case (i_req.offset)
                8'd0: begin
                    o_rdata = ctrl_rd[7:0];
                end
                8'd1: begin
                    o_rdata = ctrl_rd[15:8];
                end
                default: begin
                    o_rdata = '0;
                end
            endcase
        end
    end

    // Inverted so that a cleared register selects the internal clock
    assign o_board.mgt_ref_sel = ~ctrl_q[15];
    assign o_board.lemo_mux    = ctrl_q[14:7];
    assign o_board.ntc_mux     = ctrl_q[6:4];

endmodule

/* rtl/rrp_arbiter.sv */
`timescale 1ns/1ps

module rrp_arbiter import daq_pkg::*; #(
    parameter int N = N_SRC
) (
    input  logic                      i_bus_clk,
    input  logic                      i_bus_rst,
    input  logic [N-1:0]              i_req,
    input  logic [N-1:0]              i_hold,
    input  logic [N-1:0][WORD_W-1:0]  i_data,
    output logic [N-1:0]              o_read,
    input  logic                      i_ready,
    output logic                      o_write,
    output logic [WORD_W-1:0]         o_data
);

    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    logic [IDX_W-1:0] last_q;
    logic [IDX_W-1:0] grant_idx;
    logic             grant_vld;

    always_comb begin
        int unsigned idx;
        idx       = 0;
        grant_idx = last_q;
        grant_vld = 1'b0;
        if (i_req[last_q] && i_hold[last_q]) begin
            // Owner keeps the stream while it holds
            grant_vld = 1'b1;
        end else begin
            // Walk downwards so the nearest requester above last_q wins
            for (int k = N; k >= 1; k--) begin
                idx = (int'(last_q) + k) % N;
                if (i_req[idx]) begin
                    grant_idx = IDX_W'(idx);
                    grant_vld = 1'b1;
                end
            end
        end
    end

    always_comb begin
        o_read = '0;
        if (i_ready && grant_vld) begin
            o_read[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            last_q  <= IDX_W'(N - 1);
            o_write <= 1'b0;
        end else begin
            o_write <= |o_read;
            if (|o_read) begin
                last_q <= grant_idx;
            end
        end
    end

    // Popped word goes out with o_write on the next cycle
    always_ff @(posedge i_bus_clk) begin
        if (|o_read) begin
            o_data <= i_data[grant_idx];
        end
    end

    a_read_onehot: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        $onehot0(o_read));

    a_read_requested: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        (o_read & ~i_req) == '0);

    a_no_read_unready: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        !i_ready |-> (o_read == '0));

endmodule

/* rtl/wb_addr_decode.sv */
`timescale 1ns/1ps

module wb_addr_decode import daq_pkg::*; (
    input  logic             i_bus_clk,
    input  logic             i_bus_rst,
    input  wb_req_t          i_wb,
    output logic [DAT_W-1:0] o_wb_dat,
    output logic             o_wb_ack,
    output reg_req_t         o_sys_req,
    input  logic [DAT_W-1:0] i_sys_rdata,
    output reg_req_t         o_ctrl_req,
    input  logic [DAT_W-1:0] i_ctrl_rdata
);

    logic access;
    logic hit_sys;
    logic hit_ctrl;

    // New access only while ack is low, so a held request is served once
    assign access   = i_wb.cyc && i_wb.stb && !o_wb_ack;
    assign hit_sys  = (i_wb.adr >= SYS_BASE) && (i_wb.adr <= SYS_HIGH);
    assign hit_ctrl = (i_wb.adr >= CTRL_BASE) && (i_wb.adr <= CTRL_HIGH);

    always_comb begin
        o_sys_req.rd      = access && !i_wb.we && hit_sys;
        o_sys_req.wr      = access && i_wb.we && hit_sys;
        o_sys_req.offset  = i_wb.adr[OFS_W-1:0];
        o_sys_req.wdata   = i_wb.dat;
        o_ctrl_req.rd     = access && !i_wb.we && hit_ctrl;
        o_ctrl_req.wr     = access && i_wb.we && hit_ctrl;
        o_ctrl_req.offset = i_wb.adr[OFS_W-1:0];
        o_ctrl_req.wdata  = i_wb.dat;
    end

    always_ff @(posedge i_bus_clk) begin
        if (i_bus_rst) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= access;
        end
    end

    // Unmapped reads return zero
    always_ff @(posedge i_bus_clk) begin
        if (access && !i_wb.we) begin
            o_wb_dat <= hit_sys ? i_sys_rdata : (hit_ctrl ? i_ctrl_rdata : '0);
        end
    end

    a_ack_needs_strobe: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        $rose(o_wb_ack) |-> $past(i_wb.cyc && i_wb.stb));

    a_ack_single_cycle: assert property (@(posedge i_bus_clk) disable iff (i_bus_rst)
        o_wb_ack |=> !o_wb_ack);

endmodule
